/* Makefile */
TOP = bp_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/bp_fetch_port.sv */
// Fetch request port with one-cycle request hold and queue credit check
`timescale 1ns/1ps
`default_nettype none

module bp_fetch_port
    import bp_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Fetch request handshake
    input  logic           req_valid_i,
    input  fetch_req_t     req_i,
    output logic           req_ready_o,
    // Free slots in the prediction queue
    input  pq_cnt_t        pq_free_i,
    // Lookup toward the prediction unit
    output logic           lookup_valid_o,
    output addr_t          lookup_pc_o,
    input  bp_prediction_t pred_i,
    // Push into the prediction queue
    output logic           push_o,
    output bp_prediction_t push_data_o
);

    logic       held_valid_q;
    fetch_req_t held_req_q;
    logic       req_fire;

    // A held request already owns one free slot
    assign req_ready_o = (pq_free_i > pq_cnt_t'(held_valid_q));
    assign req_fire    = req_valid_i && req_ready_o;

    // Hold flag lives exactly one cycle per accepted request
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            held_valid_q <= 1'b0;
        end else begin
            held_valid_q <= req_fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            held_req_q <= req_i;
        end
    end

    // Combinational lookup while held
    assign lookup_valid_o = held_valid_q;
    assign lookup_pc_o    = held_req_q.pc;

    // Prediction lands in the queue at the end of the hold cycle
    assign push_o      = held_valid_q;
    assign push_data_o = pred_i;

endmodule

`default_nettype wire

/* hdl/bp_pkg.sv */
// Branch prediction package with width types, table sizes and record structs
`default_nettype none

package bp_pkg;

    // ------------------------------
    // Width types
    // ------------------------------

    // Instruction address
    typedef logic [31:0] addr_t;

    // BHT index from pc[7:2]
    typedef logic [5:0]  bht_idx_t;

    // BTB index from pc[5:2] and tag from pc[31:6]
    typedef logic [3:0]  btb_idx_t;
    typedef logic [25:0] btb_tag_t;

    // Two bit saturating counter, upper half means taken
    typedef logic [1:0]  ctr_t;

    // ------------------------------
    // Table sizes and constants
    // ------------------------------

    localparam int BHT_ENTRIES = 64;
    localparam int BTB_ENTRIES = 16;

    // Prediction queue depth and its pointer width
    localparam int PQ_DEPTH = 4;
    localparam int PQ_PTR_W = $clog2(PQ_DEPTH);

    // Weakly not taken after reset
    localparam ctr_t CTR_RESET = 2'd1;
    // Strongly taken
    localparam ctr_t CTR_MAX   = 2'd3;

    // Queue pointer and occupancy, one extra bit so a full queue fits
    typedef logic [PQ_PTR_W-1:0] pq_ptr_t;
    typedef logic [PQ_PTR_W:0]   pq_cnt_t;

    // ------------------------------
    // Records
    // ------------------------------

    // Fetch side request
    typedef struct packed {
        addr_t pc;
    } fetch_req_t;

    // Prediction handed back to fetch
    typedef struct packed {
        addr_t pc;
        logic  taken;
        logic  btb_hit;
        addr_t target;
    } bp_prediction_t;

    // Resolved control flow from execute
    typedef struct packed {
        addr_t pc;
        logic  is_branch;
        logic  is_jal;
        logic  is_jalr;
        logic  taken;
        addr_t target;
    } bp_resolve_t;

    // Table update toward the predictor
    typedef struct packed {
        addr_t pc;
        logic  taken;
        addr_t target;
        logic  is_jal;
        logic  write_btb;
    } bp_update_t;

endpackage

`default_nettype wire

/* hdl/bp_prediction_queue.sv */
// Prediction FIFO with free-slot report and valid/ready output
`timescale 1ns/1ps
`default_nettype none

module bp_prediction_queue
    import bp_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Push from the fetch port
    input  logic           push_i,
    input  bp_prediction_t push_data_i,
    output pq_cnt_t        free_o,
    // Prediction handshake toward fetch
    output logic           pred_valid_o,
    output bp_prediction_t pred_o,
    input  logic           pred_ready_i
);

    bp_prediction_t mem_q [PQ_DEPTH];
    pq_ptr_t        wr_ptr_q;
    pq_ptr_t        rd_ptr_q;
    pq_cnt_t        count_q;
    logic           do_push;
    logic           do_pop;

    // Full queue refuses the push
    assign do_push = push_i && (count_q != pq_cnt_t'(PQ_DEPTH));
    assign do_pop  = pred_valid_o && pred_ready_i;

    assign free_o       = pq_cnt_t'(PQ_DEPTH) - count_q;
    assign pred_valid_o = (count_q != '0);
    assign pred_o       = mem_q[rd_ptr_q];

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap at the power of two depth
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Push and pop together keep the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/bp_top.sv */
// Branch prediction top level with fetch port, prediction unit and queue
`timescale 1ns/1ps
`default_nettype none

module bp_top
    import bp_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Fetch requests
    input  logic           req_valid_i,
    input  fetch_req_t     req_i,
    output logic           req_ready_o,
    // Predictions
    output logic           pred_valid_o,
    output bp_prediction_t pred_o,
    input  logic           pred_ready_i,
    // Resolves from execute
    input  logic           res_valid_i,
    input  bp_resolve_t    res_i
);

    // ------------------------------
    // Internal wiring
    // ------------------------------

    pq_cnt_t        pq_free;
    logic           lookup_valid;
    addr_t          lookup_pc;
    bp_prediction_t lookup_pred;
    logic           push;
    bp_prediction_t push_data;

    bp_fetch_port u_fetch_port (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .req_ready_o    (req_ready_o),
        .pq_free_i      (pq_free),
        .lookup_valid_o (lookup_valid),
        .lookup_pc_o    (lookup_pc),
        .pred_i         (lookup_pred),
        .push_o         (push),
        .push_data_o    (push_data)
    );

    // Lookup and training
    branch_prediction_unit u_bp_unit (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .lookup_valid_i  (lookup_valid),
        .pc_i            (lookup_pc),
        .bp_prediction_o (lookup_pred),
        .res_valid_i     (res_valid_i),
        .res_i           (res_i)
    );

    // Ordered output toward fetch
    bp_prediction_queue u_pred_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_data_i  (push_data),
        .free_o       (pq_free),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred_o),
        .pred_ready_i (pred_ready_i)
    );

endmodule

`default_nettype wire

/* hdl/branch_prediction_unit.sv */
// Prediction unit with resolve classification and predictor wrapper
`timescale 1ns/1ps
`default_nettype none

module branch_prediction_unit
    import bp_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Lookup
    input  logic           lookup_valid_i,
    input  addr_t          pc_i,
    output bp_prediction_t bp_prediction_o,
    // Resolve from execute
    input  logic           res_valid_i,
    input  bp_resolve_t    res_i
);

    logic       pred_taken;
    logic       pred_hit;
    addr_t      pred_target;
    logic       update_valid;
    bp_update_t update;

    // ------------------------------
    // Resolve classification
    // ------------------------------

    // Only branches and JAL train, JALR is skipped
    assign update_valid = res_valid_i && !res_i.is_jalr && (res_i.is_branch || res_i.is_jal);

    always_comb begin
        update.pc        = res_i.pc;
        // JAL always counts as taken
        update.taken     = res_i.taken || res_i.is_jal;
        update.target    = res_i.target;
        update.is_jal    = res_i.is_jal;
        // Only taken results fill the BTB
        update.write_btb = res_i.taken || res_i.is_jal;
    end

    // ------------------------------
    // Predictor
    // ------------------------------

    branch_predictor u_branch_predictor (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .pc_i           (pc_i),
        .taken_o        (pred_taken),
        .target_o       (pred_target),
        .btb_hit_o      (pred_hit),
        .update_valid_i (update_valid),
        .update_i       (update)
    );

    // Prediction record, zero when idle
    always_comb begin
        bp_prediction_o = '0;
        if (lookup_valid_i) begin
            bp_prediction_o.pc      = pc_i;
            bp_prediction_o.taken   = pred_taken;
            bp_prediction_o.btb_hit = pred_hit;
            bp_prediction_o.target  = pred_target;
        end
    end

endmodule

`default_nettype wire

/* hdl/branch_predictor.sv */
// Branch predictor with BHT counters, tagged BTB, lookup and training
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
    import bp_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Lookup
    input  addr_t      pc_i,
    output logic       taken_o,
    output addr_t      target_o,
    output logic       btb_hit_o,
    // Training
    input  logic       update_valid_i,
    input  bp_update_t update_i
);

    // ------------------------------
    // Storage
    // ------------------------------

    ctr_t     bht_q     [BHT_ENTRIES];
    btb_tag_t btb_tag_q [BTB_ENTRIES];
    addr_t    btb_tgt_q [BTB_ENTRIES];
    logic     btb_vld_q [BTB_ENTRIES];

    // Lookup side fields
    bht_idx_t lu_bht_idx;
    btb_idx_t lu_btb_idx;
    btb_tag_t lu_tag;
    ctr_t     lu_ctr;
    logic     lu_hit;

    // Update side fields
    bht_idx_t up_bht_idx;
    btb_idx_t up_btb_idx;
    btb_tag_t up_tag;
    ctr_t     ctr_cur;
    ctr_t     ctr_next;

    // ------------------------------
    // Lookup
    // ------------------------------

    assign lu_bht_idx = bht_idx_t'(pc_i[7:2]);
    assign lu_btb_idx = btb_idx_t'(pc_i[5:2]);
    assign lu_tag     = btb_tag_t'(pc_i[31:6]);

    assign lu_ctr = bht_q[lu_bht_idx];
    // Hit needs a valid entry with a matching tag
    assign lu_hit = btb_vld_q[lu_btb_idx] && (btb_tag_q[lu_btb_idx] == lu_tag);

    // Upper counter half and a BTB hit give a taken prediction
    assign taken_o   = lu_hit && lu_ctr[1];
    assign btb_hit_o = lu_hit;
    // Fall through to the next word when not taken
    assign target_o  = taken_o ? btb_tgt_q[lu_btb_idx] : (pc_i + 32'd4);

    // ------------------------------
    // Training
    // ------------------------------

    assign up_bht_idx = bht_idx_t'(update_i.pc[7:2]);
    assign up_btb_idx = btb_idx_t'(update_i.pc[5:2]);
    assign up_tag     = btb_tag_t'(update_i.pc[31:6]);
    assign ctr_cur    = bht_q[up_bht_idx];

    // Next counter value
    always_comb begin
        ctr_next = ctr_cur;
        if (update_i.is_jal) begin
            // Jumps are always taken
            ctr_next = CTR_MAX;
        end else if (update_i.taken) begin
            if (ctr_cur != CTR_MAX) begin
                ctr_next = ctr_cur + 2'd1;
            end
        end else begin
            // Saturate at zero
            if (ctr_cur != '0) begin
                ctr_next = ctr_cur - 2'd1;
            end
        end
    end

    // Counter array
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht_q[i] <= CTR_RESET;
            end
        end else if (update_valid_i) begin
            bht_q[up_bht_idx] <= ctr_next;
        end
    end

    // BTB arrays, written only for taken results
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_vld_q[i] <= 1'b0;
                btb_tag_q[i] <= '0;
                btb_tgt_q[i] <= '0;
            end
        end else if (update_valid_i && update_i.write_btb) begin
            // Direct mapped, so a new tag evicts the old one
            btb_vld_q[up_btb_idx] <= 1'b1;
            btb_tag_q[up_btb_idx] <= up_tag;
            btb_tgt_q[up_btb_idx] <= update_i.target;
        end
    end

endmodule

`default_nettype wire

/* tests/bp_asserts.sv */
// Handshake stability and queue state assertions bound into bp_top
`timescale 1ns/1ps
`default_nettype none

module bp_asserts
    import bp_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           req_valid_i,
    input  fetch_req_t     req_i,
    input  logic           req_ready_o,
    input  logic           pred_valid_o,
    input  bp_prediction_t pred_o,
    input  logic           pred_ready_i,
    // Push from the fetch port into the queue
    input  logic           push_i
);

    // Occupancy rebuilt from pushes and output transfers
    pq_cnt_t occ_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_q + pq_cnt_t'(push_i) - pq_cnt_t'(pred_valid_o && pred_ready_i);
        end
    end

    // Fetch keeps a stalled request steady
    req_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
        else $error("Request dropped or changed while stalled");

    // Queue head holds while fetch stalls
    pred_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pred_valid_o && !pred_ready_i |=> pred_valid_o && $stable(pred_o))
        else $error("Prediction dropped or changed while stalled");

    pred_idle_after_reset_a : assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !pred_valid_o)
        else $error("Prediction valid right after reset");

    // Nothing pushed and not yet taken means nothing to offer
    pred_not_from_empty_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (occ_q == '0) |-> !pred_valid_o)
        else $error("Prediction valid from an empty queue");

endmodule

bind bp_top bp_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .pred_valid_o (pred_valid_o),
    .pred_o       (pred_o),
    .pred_ready_i (pred_ready_i),
    .push_i       (push)
);

`default_nettype wire

/* tests/bp_input.txt */
# R pc kind(B branch, J jal, X jalr) taken target
# L pc exp_taken exp_btb_hit exp_target, all numbers in hex
# After reset nothing is known
L 00001000 0 0 00001004
L 00002040 0 0 00002044
# Branch training on 00001010
R 00001010 B 1 00001100
L 00001010 1 1 00001100
R 00001010 B 1 00001100
L 00001010 1 1 00001100
R 00001010 B 0 00001014
L 00001010 1 1 00001100
R 00001010 B 0 00001014
L 00001010 0 1 00001014
R 00001010 B 0 00001014
L 00001010 0 1 00001014
# JAL trains at once, lookup just before sees the old tables
L 00003020 0 0 00003024
R 00003020 J 1 00004000
L 00003020 1 1 00004000
# JALR leaves the tables alone
R 00005030 X 1 00006000
L 00005030 0 0 00005034
# Aliasing on BTB index 6
R 00007018 B 1 00007200
L 00007018 1 1 00007200
R 00008018 B 1 00008300
L 00008018 1 1 00008300
L 00007018 0 0 0000701c
# Back-to-back burst under random back-pressure
L 00001010 0 1 00001014
L 00003020 1 1 00004000
L 00008018 1 1 00008300
L 00007018 0 0 0000701c
L 00005030 0 0 00005034
L 00001000 0 0 00001004
L 00003020 1 1 00004000
L 00001010 0 1 00001014
L 00008018 1 1 00008300
L 00002040 0 0 00002044
L 00003020 1 1 00004000
L 00007018 0 0 0000701c
L 00008018 1 1 00008300
L 00005030 0 0 00005034
L 00001010 0 1 00001014
L 00003020 1 1 00004000

/* tests/bp_tb.sv */
// Testbench for bp_top with file driven resolves and lookups, scoreboard, timeout and report
`timescale 1ns/1ps
`default_nettype none

module bp_tb
    import bp_pkg::*;
();

    // One operation from the data file
    typedef struct packed {
        logic [7:0] code;
        addr_t      pc;
        logic [7:0] flag;
        addr_t      arg3;
        addr_t      arg4;
    } op_t;

    logic           clk_i;
    logic           rst_n_i;
    logic           req_valid_i;
    fetch_req_t     req_i;
    logic           req_ready_o;
    logic           pred_valid_o;
    bp_prediction_t pred_o;
    logic           pred_ready_i;
    logic           res_valid_i;
    bp_resolve_t    res_i;

    op_t            ops_q[$];
    // Expected predictions in request order
    bp_prediction_t exp_q[$];
    int             line_count;
    int             cycle_count;
    int             cycle_limit;
    int             test_count;
    int             error_count;
    bit             stall_seen;
    bit             after_resolve;

    bp_top dut_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred_o),
        .pred_ready_i (pred_ready_i),
        .res_valid_i  (res_valid_i),
        .res_i        (res_i)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_taken(input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail pred_o.taken got 0x%h exp 0x%h", got, exp);
        end
    endtask

    task automatic check_btb_hit(input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail pred_o.btb_hit got 0x%h exp 0x%h", got, exp);
        end
    endtask

    task automatic check_target(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail pred_o.target got 0x%h exp 0x%h", got, exp);
        end
    endtask

    task automatic check_pred_pc(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail pred_o.pc got 0x%h exp 0x%h", got, exp);
        end
    endtask

    // Compares the head of the queue with the oldest pending lookup
    task automatic check_prediction();
        bp_prediction_t exp_p;
        int             errs_before;
        if (exp_q.size() == 0) begin
            error_count++;
            $display("Prediction for pc 0x%h arrived with no lookup pending", pred_o.pc);
        end else begin
            exp_p       = exp_q.pop_front();
            errs_before = error_count;
            check_pred_pc(pred_o.pc, exp_p.pc);
            check_taken(pred_o.taken, exp_p.taken);
            check_btb_hit(pred_o.btb_hit, exp_p.btb_hit);
            check_target(pred_o.target, exp_p.target);
            test_count++;
            $display("Lookup %0d pc 0x%h %s", test_count, exp_p.pc,
                     (error_count == errs_before) ? "ok" : "failed");
        end
    endtask

    // ------------------------------
    // Data file and drivers
    // ------------------------------

    task automatic read_ops();
        int         fd;
        int         fields;
        string      line;
        logic [7:0] code;
        logic [7:0] flag;
        addr_t      pc;
        addr_t      arg3;
        addr_t      arg4;
        op_t        op;
        fd = $fopen("tests/bp_input.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open tests/bp_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0) begin
                    line_count++;
                    // Lines starting with # are comments
                    if (line[0] != "#") begin
                        fields = $sscanf(line, "%c %h %c %h %h", code, pc, flag, arg3, arg4);
                        if (fields == 5) begin
                            op = '{code: code, pc: pc, flag: flag, arg3: arg3, arg4: arg4};
                            ops_q.push_back(op);
                        end else begin
                            error_count++;
                            $display("Data file line %0d could not be parsed", line_count);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        res_valid_i <= 1'b0;
    endtask

    // Resolve is valid for exactly one edge
    task automatic drive_resolve(input op_t op);
        bp_resolve_t rec;
        rec           = '0;
        rec.pc        = op.pc;
        rec.is_branch = (op.flag == "B");
        rec.is_jal    = (op.flag == "J");
        rec.is_jalr   = (op.flag == "X");
        rec.taken     = op.arg3[0];
        rec.target    = op.arg4;
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        res_valid_i <= 1'b1;
        res_i       <= rec;
    endtask

    task automatic drive_lookup(input op_t op);
        bp_prediction_t exp_p;
        exp_p.pc      = op.pc;
        exp_p.taken   = (op.flag == "1");
        exp_p.btb_hit = op.arg3[0];
        exp_p.target  = op.arg4;
        @(posedge clk_i);
        res_valid_i <= 1'b0;
        req_valid_i <= 1'b1;
        req_i.pc    <= op.pc;
        exp_q.push_back(exp_p);
        // Transfer happens on the next edge that sees ready high
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
    endtask

    // ------------------------------
    // Monitors
    // ------------------------------

    // Mid-cycle sampling keeps handshakes clear of the clock edge
    always @(negedge clk_i) begin
        if (rst_n_i && pred_valid_o && pred_ready_i) begin
            check_prediction();
        end
        if (rst_n_i && req_valid_i && !req_ready_o) begin
            stall_seen = 1'b1;
        end
    end

    // Fetch stalls on about half of the cycles
    always @(posedge clk_i) begin
        pred_ready_i <= (($urandom % 2) == 0);
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d lookups still pending",
                     cycle_count, exp_q.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        req_valid_i   = 1'b0;
        req_i         = '0;
        pred_ready_i  = 1'b0;
        res_valid_i   = 1'b0;
        res_i         = '0;
        line_count    = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        test_count    = 0;
        error_count   = 0;
        stall_seen    = 1'b0;
        after_resolve = 1'b0;
        void'($urandom(32'h3769_7c47));
        read_ops();
        cycle_limit = 20 * line_count + 100;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        foreach (ops_q[i]) begin
            if (ops_q[i].code == "R") begin
                drive_resolve(ops_q[i]);
                after_resolve = 1'b1;
            end else begin
                // Let a fresh resolve reach the tables first
                if (after_resolve) begin
                    idle_cycle();
                end
                drive_lookup(ops_q[i]);
                after_resolve = 1'b0;
            end
        end
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        if (!stall_seen) begin
            error_count++;
            $display("req_ready_o never went low while lookups were waiting");
        end
        $display("Tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/bp_pkg.sv
hdl/bp_fetch_port.sv
hdl/branch_predictor.sv
hdl/branch_prediction_unit.sv
hdl/bp_prediction_queue.sv
hdl/bp_top.sv
tests/bp_asserts.sv
tests/bp_tb.sv
